// ==== hw/fabric_defs.svh ====
`ifndef FABRIC_DEFS_SVH
`define FABRIC_DEFS_SVH

// ==============================
// buffering
// ==============================

// entries in every input and output FIFO
`define FABRIC_FIFO_DEPTH 4

// ==============================
// router geometry
// ==============================

// north, east, south, west and local
// port index matches the cardinal value
`define FABRIC_NUM_PORTS 5

// ==============================
// address layout
// ==============================

// destination tile id sits in the top byte of the address
// column in the upper nibble, row in the lower nibble
`define FABRIC_TILE_MSB 31
`define FABRIC_TILE_LSB 24

`endif

// ==== hw/fabric_pkg.sv ====
package fabric_pkg;

    // ==============================
    // mesh addressing
    // ==============================

    // direction of travel out of a tile
    // the value doubles as the router port index
    typedef enum logic [2:0] {
        NORTH         = 3'd0,
        EAST          = 3'd1,
        SOUTH         = 3'd2,
        WEST          = 3'd3,
        LOCAL         = 3'd4,
        NULL_CARDINAL = 3'd7
    } t_cardinal;

    // row grows southward, column grows eastward
    typedef struct packed {
        logic [3:0] col;
        logic [3:0] row;
    } t_tile_id;

    // one request as issued by a core
    typedef struct packed {
        logic [31:0] address;
        logic [31:0] data;
    } t_req;

endpackage

// ==== hw/router_pkg.sv ====
package router_pkg;

    // ==============================
    // link level flit
    // ==============================

    // a request on the wire between two tiles
    // route is the output the receiving tile must take,
    // already computed one hop earlier
    typedef struct packed {
        fabric_pkg::t_req      req;
        fabric_pkg::t_cardinal route;
    } t_link_flit;

    // 64 bit request plus 3 bit route
    localparam int LINK_FLIT_W = $bits(t_link_flit);

    // ready/valid convention on every link
    // transfer happens when both are high at a rising edge
    // payload is held stable while valid waits for ready

endpackage

// ==== hw/flit_fifo.sv ====
`timescale 1ns/100ps
`include "fabric_defs.svh"

module flit_fifo #(
    parameter type PAYLOAD_T = logic,
    parameter int  DEPTH     = `FABRIC_FIFO_DEPTH
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  PAYLOAD_T in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output PAYLOAD_T out_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    PAYLOAD_T         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_next;
    logic             wr_en;
    logic             rd_en;

    // full is the only thing that blocks a write
    assign in_ready = (count != CNT_W'(DEPTH));
    assign wr_en    = in_valid && in_ready;
    assign rd_en    = out_valid && out_ready;
    // head is read straight from the array
    assign out_data = mem[rd_ptr];

    always_comb begin
        count_next = count;
        if (wr_en && !rd_en) begin
            count_next = count + 1'b1;
        end else if (rd_en && !wr_en) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            out_valid <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count_next;
            // valid comes from a flop, a fresh entry shows one edge after its write
            out_valid <= (count_next != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // a write never lands on an entry still waiting to be read
    a_no_write_full: assert property (@(posedge clk) disable iff (rst)
        wr_en && (count != '0) |-> (wr_ptr != rd_ptr))
        else $error("flit_fifo: write over an unread entry");

    // a read only takes a slot that holds an entry
    a_no_read_empty: assert property (@(posedge clk) disable iff (rst)
        rd_en |-> (count == CNT_W'(DEPTH)) || (rd_ptr != wr_ptr))
        else $error("flit_fifo: read from empty buffer");

endmodule

// ==== hw/input_stage.sv ====
`timescale 1ns/100ps
`include "fabric_defs.svh"

module input_stage (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                  [`FABRIC_NUM_PORTS-1:0] in_valid,
    output logic                  [`FABRIC_NUM_PORTS-1:0] in_ready,
    input  router_pkg::t_link_flit [`FABRIC_NUM_PORTS-1:0] in_flit,
    input  fabric_pkg::t_cardinal                          local_route,
    output logic                  [`FABRIC_NUM_PORTS-1:0] head_valid,
    output router_pkg::t_link_flit [`FABRIC_NUM_PORTS-1:0] head_flit,
    output fabric_pkg::t_cardinal [`FABRIC_NUM_PORTS-1:0] head_route,
    input  logic                  [`FABRIC_NUM_PORTS-1:0] pop
);

    for (genvar i = 0; i < `FABRIC_NUM_PORTS; i++) begin : g_port
        router_pkg::t_link_flit fifo_flit;
        logic                   fifo_valid;
        logic                   discard;

        flit_fifo #(.PAYLOAD_T(router_pkg::t_link_flit)) in_fifo_inst (
            .clk       (clk),
            .rst       (rst),
            .in_valid  (in_valid[i]),
            .in_ready  (in_ready[i]),
            .in_data   (in_flit[i]),
            .out_valid (fifo_valid),
            .out_ready (pop[i] || discard),
            .out_data  (fifo_flit)
        );

        if (i == int'(fabric_pkg::LOCAL)) begin : g_local
            // injected flits carry no route, the local route unit supplies it
            assign discard       = 1'b0;
            assign head_route[i] = local_route;
        end else begin : g_link
            // null route means drop, popped on the next edge
            assign discard       = fifo_valid && (fifo_flit.route == fabric_pkg::NULL_CARDINAL);
            assign head_route[i] = fifo_flit.route;
        end

        // dropped heads are never shown to routing or arbitration
        assign head_valid[i] = fifo_valid && !discard;
        assign head_flit[i]  = fifo_flit;

        // the arbiter only pops what this stage offered
        a_pop_valid: assert property (@(posedge clk) disable iff (rst)
            pop[i] |-> head_valid[i])
            else $error("input_stage: pop on port %0d without a valid head", i);
    end

endmodule

// ==== hw/next_tile_route.sv ====
`timescale 1ns/100ps
`include "fabric_defs.svh"

module next_tile_route #(
    parameter fabric_pkg::t_cardinal NEXT_TILE_CARDINAL = fabric_pkg::NULL_CARDINAL
) (
    input  logic                                         clk,
    input  fabric_pkg::t_tile_id                         local_tile_id,
    input  logic                 [`FABRIC_NUM_PORTS-1:0] req_valid,
    input  logic                 [`FABRIC_NUM_PORTS-1:0][7:0] req_address,
    output fabric_pkg::t_cardinal [`FABRIC_NUM_PORTS-1:0] next_route
);

    fabric_pkg::t_tile_id next_tile_id;

    // dimension ordered choice made at tile here for destination dest
    // row first, then column, then delivery
    function automatic fabric_pkg::t_cardinal dor_route(
        input fabric_pkg::t_tile_id here,
        input fabric_pkg::t_tile_id dest
    );
        if (dest.row < here.row) begin
            return fabric_pkg::NORTH;
        end else if (dest.row > here.row) begin
            return fabric_pkg::SOUTH;
        end else if (dest.col < here.col) begin
            return fabric_pkg::WEST;
        end else if (dest.col > here.col) begin
            return fabric_pkg::EAST;
        end
        return fabric_pkg::LOCAL;
    endfunction

    // ==============================
    // neighbor id
    // ==============================
    // no wrap at the mesh edge
    if (NEXT_TILE_CARDINAL == fabric_pkg::NORTH) begin : g_north
        assign next_tile_id.col = local_tile_id.col;
        assign next_tile_id.row = local_tile_id.row - 4'd1;
    end else if (NEXT_TILE_CARDINAL == fabric_pkg::SOUTH) begin : g_south
        assign next_tile_id.col = local_tile_id.col;
        assign next_tile_id.row = local_tile_id.row + 4'd1;
    end else if (NEXT_TILE_CARDINAL == fabric_pkg::EAST) begin : g_east
        assign next_tile_id.col = local_tile_id.col + 4'd1;
        assign next_tile_id.row = local_tile_id.row;
    end else if (NEXT_TILE_CARDINAL == fabric_pkg::WEST) begin : g_west
        assign next_tile_id.col = local_tile_id.col - 4'd1;
        assign next_tile_id.row = local_tile_id.row;
    end else begin : g_self
        // local instance routes for this very tile
        assign next_tile_id = local_tile_id;
    end

    // ==============================
    // route at the neighbor
    // ==============================
    always_comb begin
        for (int i = 0; i < `FABRIC_NUM_PORTS; i++) begin
            if (req_valid[i]) begin
                next_route[i] = dor_route(next_tile_id, fabric_pkg::t_tile_id'(req_address[i]));
            end else begin
                next_route[i] = fabric_pkg::NULL_CARDINAL;
            end
        end
    end

    // a head that leaves toward this neighbor must not be sent straight back
    if (NEXT_TILE_CARDINAL <= fabric_pkg::WEST) begin : g_no_turn_back
        localparam fabric_pkg::t_cardinal BACK =
            fabric_pkg::t_cardinal'((int'(NEXT_TILE_CARDINAL) + 2) % 4);
        for (genvar i = 0; i < `FABRIC_NUM_PORTS; i++) begin : g_head
            a_no_turn_back: assert property (@(posedge clk)
                req_valid[i] &&
                (dor_route(local_tile_id, fabric_pkg::t_tile_id'(req_address[i])) ==
                 NEXT_TILE_CARDINAL)
                |-> (next_route[i] != BACK))
                else $error("next_tile_route: head %0d turned back toward this tile", i);
        end
    end

endmodule

// ==== hw/output_arbiter.sv ====
`timescale 1ns/100ps
`include "fabric_defs.svh"

module output_arbiter (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                  [`FABRIC_NUM_PORTS-1:0] head_valid,
    input  router_pkg::t_link_flit [`FABRIC_NUM_PORTS-1:0] head_flit,
    input  fabric_pkg::t_cardinal [`FABRIC_NUM_PORTS-1:0] head_route,
    input  fabric_pkg::t_cardinal [`FABRIC_NUM_PORTS-1:0][`FABRIC_NUM_PORTS-1:0] next_route,
    output logic                  [`FABRIC_NUM_PORTS-1:0] pop,
    output logic                  [`FABRIC_NUM_PORTS-1:0] out_valid,
    input  logic                  [`FABRIC_NUM_PORTS-1:0] out_ready,
    output router_pkg::t_link_flit [`FABRIC_NUM_PORTS-1:0] out_flit
);

    localparam int N     = `FABRIC_NUM_PORTS;
    localparam int IDX_W = $clog2(N);

    // indexed by output, then by input
    logic [N-1:0][N-1:0]   grant;
    // indexed by input, then by output
    logic [N-1:0][N-1:0]   grant_t;
    logic [N-1:0][IDX_W-1:0] win_idx;
    logic [N-1:0][IDX_W-1:0] rr_ptr;
    logic [N-1:0]          out_space;
    logic [N-1:0]          wr_valid;

    // ==============================
    // round robin pick
    // ==============================
    always_comb begin
        int   idx;
        logic found;
        for (int k = 0; k < N; k++) begin
            grant[k]   = '0;
            win_idx[k] = '0;
            found      = 1'b0;
            // scan from the pointer, first requester wins
            for (int n = 0; n < N; n++) begin
                idx = (int'(rr_ptr[k]) + n) % N;
                if (!found && out_space[k] && head_valid[idx] &&
                    (head_route[idx] == fabric_pkg::t_cardinal'(k))) begin
                    grant[k][idx] = 1'b1;
                    win_idx[k]    = IDX_W'(idx);
                    found         = 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < N; i++) begin
            for (int k = 0; k < N; k++) begin
                grant_t[i][k] = grant[k][i];
            end
        end
    end

    // pointer moves one past the last winner
    always_ff @(posedge clk) begin
        if (rst) begin
            rr_ptr <= '0;
        end else begin
            for (int k = 0; k < N; k++) begin
                if (wr_valid[k]) begin
                    rr_ptr[k] <= (win_idx[k] == IDX_W'(N - 1)) ? '0 : win_idx[k] + 1'b1;
                end
            end
        end
    end

    // ==============================
    // output buffers
    // ==============================
    for (genvar k = 0; k < N; k++) begin : g_out
        router_pkg::t_link_flit wr_flit;

        assign wr_valid[k] = |grant[k];

        // swap in the route the neighbor in direction k will need
        always_comb begin
            wr_flit       = head_flit[win_idx[k]];
            wr_flit.route = next_route[k][win_idx[k]];
        end

        flit_fifo #(.PAYLOAD_T(router_pkg::t_link_flit)) out_fifo_inst (
            .clk       (clk),
            .rst       (rst),
            .in_valid  (wr_valid[k]),
            .in_ready  (out_space[k]),
            .in_data   (wr_flit),
            .out_valid (out_valid[k]),
            .out_ready (out_ready[k]),
            .out_data  (out_flit[k])
        );

        a_grant_onehot: assert property (@(posedge clk) disable iff (rst)
            $onehot0(grant[k]))
            else $error("output_arbiter: several grants on output %0d", k);
    end

    for (genvar i = 0; i < N; i++) begin : g_in
        // a head is popped once its output FIFO took it
        assign pop[i] = |grant_t[i];

        a_input_single: assert property (@(posedge clk) disable iff (rst)
            $onehot0(grant_t[i]))
            else $error("output_arbiter: input %0d granted to several outputs", i);
    end

endmodule

// ==== hw/mesh_router.sv ====
`timescale 1ns/100ps
`include "fabric_defs.svh"

module mesh_router (
    input  logic                                          clk,
    input  logic                                          rst,
    input  fabric_pkg::t_tile_id                          local_tile_id,
    input  logic                  [`FABRIC_NUM_PORTS-1:0] in_valid,
    output logic                  [`FABRIC_NUM_PORTS-1:0] in_ready,
    input  router_pkg::t_link_flit [`FABRIC_NUM_PORTS-1:0] in_flit,
    output logic                  [`FABRIC_NUM_PORTS-1:0] out_valid,
    input  logic                  [`FABRIC_NUM_PORTS-1:0] out_ready,
    output router_pkg::t_link_flit [`FABRIC_NUM_PORTS-1:0] out_flit
);

    localparam int N = `FABRIC_NUM_PORTS;

    logic                   [N-1:0]         head_valid;
    router_pkg::t_link_flit [N-1:0]         head_flit;
    fabric_pkg::t_cardinal  [N-1:0]         head_route;
    logic                   [N-1:0]         pop;
    logic                   [N-1:0][7:0]    head_address;
    // indexed by output direction, then by input
    fabric_pkg::t_cardinal  [N-1:0][N-1:0]  next_route;

    input_stage input_stage_inst (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_flit     (in_flit),
        // local head is routed here by the LOCAL unit
        .local_route (next_route[fabric_pkg::LOCAL][fabric_pkg::LOCAL]),
        .head_valid  (head_valid),
        .head_flit   (head_flit),
        .head_route  (head_route),
        .pop         (pop)
    );

    // ==============================
    // lookahead route units
    // ==============================
    for (genvar k = 0; k < N; k++) begin : g_route
        // destination tile field of each head
        assign head_address[k] = head_flit[k].req.address[`FABRIC_TILE_MSB:`FABRIC_TILE_LSB];

        next_tile_route #(.NEXT_TILE_CARDINAL(fabric_pkg::t_cardinal'(k))) route_inst (
            .clk           (clk),
            .local_tile_id (local_tile_id),
            .req_valid     (head_valid),
            .req_address   (head_address),
            .next_route    (next_route[k])
        );
    end

    output_arbiter output_arbiter_inst (
        .clk        (clk),
        .rst        (rst),
        .head_valid (head_valid),
        .head_flit  (head_flit),
        .head_route (head_route),
        .next_route (next_route),
        .pop        (pop),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_flit   (out_flit)
    );

endmodule

// ==== tb/mesh_router_tb.sv ====
`timescale 1ns/100ps
`include "fabric_defs.svh"

module mesh_router_tb;

    localparam int N              = `FABRIC_NUM_PORTS;
    localparam int CLK_PERIOD     = 100;
    localparam int SEED           = 37;
    localparam int FLITS_PER_PORT = 60;
    localparam int TOTAL_FLITS    = N * FLITS_PER_PORT;
    // generous bound, 40 clock periods per flit
    localparam longint WATCHDOG_NS = 40 * TOTAL_FLITS * CLK_PERIOD;
    localparam fabric_pkg::t_tile_id HOME = fabric_pkg::t_tile_id'(8'h55);

    logic                           clk;
    logic                           rst;
    fabric_pkg::t_tile_id           local_tile_id = HOME;
    logic                   [N-1:0] in_valid      = '0;
    logic                   [N-1:0] in_ready;
    router_pkg::t_link_flit [N-1:0] in_flit       = '0;
    logic                   [N-1:0] out_valid;
    logic                   [N-1:0] out_ready     = '1;
    router_pkg::t_link_flit [N-1:0] out_flit;

    // scoreboard, one queue per input and output pair
    fabric_pkg::t_req sb_q [N][N][$];
    int sent [N] = '{default: 0};
    int pending    = 0;
    int received   = 0;
    int dropped    = 0;
    int accepted   = 0;
    int pending_q  = 0;
    int accepted_q = 0;
    logic driving  = 1'b0;
    logic end_chk  = 1'b0;

    // staged compare values, checked one edge after the output transfer
    logic                   [N-1:0] chk_v = '0;
    fabric_pkg::t_cardinal  [N-1:0] exp_port;
    fabric_pkg::t_cardinal  [N-1:0] exp_route;
    fabric_pkg::t_cardinal  [N-1:0] act_route;
    fabric_pkg::t_req       [N-1:0] exp_req;
    fabric_pkg::t_req       [N-1:0] act_req;
    router_pkg::t_link_flit [N-1:0] held_flit;

    int err_port  = 0;
    int err_route = 0;
    int err_data  = 0;
    int err_hold  = 0;
    int err_reset = 0;
    int err_drain = 0;

    mesh_router mesh_router_inst (
        .clk           (clk),
        .rst           (rst),
        .local_tile_id (local_tile_id),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_flit       (in_flit),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_flit      (out_flit)
    );

    // ==============================
    // reference rules
    // ==============================

    // later tests override earlier ones, so rows win over columns
    function automatic fabric_pkg::t_cardinal dim_order_route(
        input fabric_pkg::t_tile_id at,
        input fabric_pkg::t_tile_id dest
    );
        fabric_pkg::t_cardinal dir;
        dir = fabric_pkg::LOCAL;
        if (dest.col > at.col) dir = fabric_pkg::EAST;
        if (dest.col < at.col) dir = fabric_pkg::WEST;
        if (dest.row > at.row) dir = fabric_pkg::SOUTH;
        if (dest.row < at.row) dir = fabric_pkg::NORTH;
        return dir;
    endfunction

    function automatic fabric_pkg::t_tile_id neighbor_of(
        input fabric_pkg::t_tile_id at,
        input int dir
    );
        fabric_pkg::t_tile_id nb;
        nb = at;
        case (dir)
            0: nb.row = at.row - 4'd1;
            1: nb.col = at.col + 4'd1;
            2: nb.row = at.row + 4'd1;
            3: nb.col = at.col - 4'd1;
            default: nb = at;
        endcase
        return nb;
    endfunction

    function automatic fabric_pkg::t_tile_id dest_of(input fabric_pkg::t_req req);
        return fabric_pkg::t_tile_id'(req.address[`FABRIC_TILE_MSB:`FABRIC_TILE_LSB]);
    endfunction

    // data carries the input index and a sequence number, so every flit is unique
    function automatic router_pkg::t_link_flit make_flit(input int p, input int seq);
        router_pkg::t_link_flit f;
        fabric_pkg::t_tile_id   dest;
        dest.col = 4'($urandom_range(3, 7));
        dest.row = 4'($urandom_range(3, 7));
        // a flit from a link has already done the hops behind it
        case (p)
            0: dest.row = 4'($urandom_range(5, 7));
            2: dest.row = 4'($urandom_range(3, 5));
            1: begin
                dest.row = HOME.row;
                dest.col = 4'($urandom_range(3, 5));
            end
            3: begin
                dest.row = HOME.row;
                dest.col = 4'($urandom_range(5, 7));
            end
            default: ;
        endcase
        f.req.address = {dest, 24'($urandom)};
        f.req.data    = {4'(p), 28'(seq)};
        if (p == int'(fabric_pkg::LOCAL)) begin
            // local route field is junk, the router must ignore it
            f.route = fabric_pkg::t_cardinal'($urandom_range(0, 7));
        end else if ($urandom_range(0, 15) == 0) begin
            f.route = fabric_pkg::NULL_CARDINAL;
        end else begin
            f.route = dim_order_route(HOME, dest);
        end
        return f;
    endfunction

    task automatic report_counts();
        $display("errors: output_port=%0d next_route=%0d data_order=%0d hold_stable=%0d %s%0d %s%0d",
                 err_port, err_route, err_data, err_hold, "reset_state=", err_reset,
                 "drain=", err_drain);
    endtask

    // ==============================
    // clock, reset and stimulus
    // ==============================
    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        if (driving) begin
            for (int p = 0; p < N; p++) begin
                // slot is free when idle or when the held flit is taken at this edge
                if (!in_valid[p] || in_ready[p]) begin
                    if (sent[p] < FLITS_PER_PORT && $urandom_range(0, 3) != 0) begin
                        in_flit[p]  <= make_flit(p, sent[p]);
                        in_valid[p] <= 1'b1;
                        sent[p]      = sent[p] + 1;
                    end else begin
                        in_valid[p] <= 1'b0;
                    end
                end
                // low about 30% of the time
                out_ready[p] <= ($urandom_range(0, 9) >= 3);
            end
        end
    end

    // ==============================
    // monitor and scoreboard
    // ==============================
    always @(posedge clk) begin
        router_pkg::t_link_flit f;
        int src;
        int hit;
        chk_v <= '0;
        if (!rst) begin
            for (int p = 0; p < N; p++) begin
                if (in_valid[p] && in_ready[p]) begin
                    f        = in_flit[p];
                    accepted = accepted + 1;
                    if (p == int'(fabric_pkg::LOCAL)) begin
                        sb_q[p][int'(dim_order_route(HOME, dest_of(f.req)))].push_back(f.req);
                        pending = pending + 1;
                    end else if (f.route == fabric_pkg::NULL_CARDINAL) begin
                        dropped = dropped + 1;
                    end else begin
                        sb_q[p][int'(f.route)].push_back(f.req);
                        pending = pending + 1;
                    end
                end
            end
            for (int k = 0; k < N; k++) begin
                if (out_valid[k] && out_ready[k]) begin
                    f   = out_flit[k];
                    src = int'(f.req.data[31:28]);
                    hit = -1;
                    // only queue heads may match, which enforces the order
                    for (int j = 0; j < N; j++) begin
                        if (src < N && hit < 0 && sb_q[src][j].size() != 0) begin
                            if (sb_q[src][j][0] == f.req) hit = j;
                        end
                    end
                    if (hit >= 0) begin
                        exp_port[k] <= fabric_pkg::t_cardinal'(hit);
                        exp_req[k]  <= sb_q[src][hit].pop_front();
                        pending      = pending - 1;
                    end else begin
                        // expected nowhere, e.g. a dropped or reordered flit
                        exp_port[k] <= fabric_pkg::NULL_CARDINAL;
                        if (src < N && sb_q[src][k].size() != 0) begin
                            exp_req[k] <= sb_q[src][k][0];
                        end else begin
                            exp_req[k] <= '0;
                        end
                    end
                    exp_route[k] <= dim_order_route(neighbor_of(HOME, k), dest_of(f.req));
                    act_route[k] <= f.route;
                    act_req[k]   <= f.req;
                    chk_v[k]     <= 1'b1;
                    received      = received + 1;
                end
            end
        end
        pending_q  <= pending;
        accepted_q <= accepted;
    end

    always @(posedge clk) begin
        held_flit <= out_flit;
    end

    // ==============================
    // assertions
    // ==============================
    for (genvar k = 0; k < N; k++) begin : g_check
        a_port: assert property (@(posedge clk) chk_v[k] |-> (exp_port[k] == k))
            else begin
                err_port++;
                $display("error output_port: expected %0d actual %0d", $sampled(exp_port[k]), k);
            end

        a_route: assert property (@(posedge clk) chk_v[k] |-> (act_route[k] == exp_route[k]))
            else begin
                err_route++;
                $display("error next_route: output %0d expected %0d actual %0d",
                         k, $sampled(exp_route[k]), $sampled(act_route[k]));
            end

        a_data: assert property (@(posedge clk) chk_v[k] |-> (act_req[k] == exp_req[k]))
            else begin
                err_data++;
                $display("error data_order: output %0d expected %h actual %h",
                         k, $sampled(exp_req[k]), $sampled(act_req[k]));
            end

        // a stalled flit stays put until taken
        a_hold: assert property (@(posedge clk) disable iff (rst)
            out_valid[k] && !out_ready[k] |=> out_valid[k] && (out_flit[k] == held_flit[k]))
            else begin
                err_hold++;
                $display("error hold_stable: output %0d expected %h actual %h",
                         k, $sampled(held_flit[k]), $sampled(out_flit[k]));
            end
    end

    a_reset: assert property (@(posedge clk) rst |=> (out_valid == '0) && (in_ready == '1))
        else begin
            err_reset++;
            $display("error reset_state: expected %h actual %h", {N'(0), {N{1'b1}}},
                     {$sampled(out_valid), $sampled(in_ready)});
        end

    a_drain: assert property (@(posedge clk) end_chk |-> (pending_q == 0) && (out_valid == '0))
        else begin
            err_drain++;
            $display("error drain: expected 0 actual %0d", $sampled(pending_q));
        end

    // ==============================
    // run control
    // ==============================
    initial begin
        void'($urandom(SEED));
        rst = 1'b1;
        repeat (16) @(posedge clk);
        rst     <= 1'b0;
        driving <= 1'b1;
        do begin
            @(posedge clk);
        end while (!(accepted_q == TOTAL_FLITS && in_valid == '0 && pending_q == 0));
        // idle time so any stray flit would still show up
        repeat (20) @(posedge clk);
        end_chk <= 1'b1;
        @(posedge clk);
        end_chk <= 1'b0;
        repeat (2) @(posedge clk);
        report_counts();
        if (err_port + err_route + err_data + err_hold + err_reset + err_drain == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("run timed out with %0d flits still missing", TOTAL_FLITS - dropped - received);
        report_counts();
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+hw
hw/fabric_pkg.sv
hw/router_pkg.sv
hw/flit_fifo.sv
hw/input_stage.sv
hw/next_tile_route.sv
hw/output_arbiter.sv
hw/mesh_router.sv
tb/mesh_router_tb.sv

// ==== Bender.yml ====
package:
  name: mesh_router

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/fabric_pkg.sv
      - hw/router_pkg.sv
      - hw/flit_fifo.sv
      - hw/input_stage.sv
      - hw/next_tile_route.sv
      - hw/output_arbiter.sv
      - hw/mesh_router.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/mesh_router_tb.sv
